// ==== source/emmu_consts.svh ====
`ifndef EMMU_CONSTS_SVH
`define EMMU_CONSTS_SVH

// ############################
// translation table
// ############################
`define EMMU_TABLE_AW      12   // index width, 4096 entries
`define EMMU_TABLE_DW      48   // entry width, 12 addr bits + 32 upper word + spare

// ############################
// flow control
// ############################
`define EMMU_FIFO_DEPTH    4    // output fifo entries, power of two
`define EMMU_IN_CREDITS    4    // sender credits after reset, same as fifo depth
`define EMMU_OUT_CREDITS   4    // downstream credits after reset

// ############################
// config address map
// ############################
`define EMMU_CTRL_SEL_BIT  16   // 1 = control reg, 0 = table
`define EMMU_BID_BIT       15   // must match block id
`define EMMU_HALF_BIT      2    // 0 = entry bits 31:0, 1 = bits 47:32
`define EMMU_IDX_LSB       3    // table index lives in 14:3

`endif

// ==== source/emesh_pkg.sv ====
`include "emmu_consts.svh"

package emesh_pkg;

   // ############################
   // mesh packet
   // ############################

   // 104 bits, field order fixed by the mesh
   typedef struct packed {
      logic [31:0] srcaddr;   // return address for reads
      logic [31:0] data;      // write data
      logic [31:0] dstaddr;   // target, top 12 bits get translated
      logic [4:0]  ctrlmode;
      logic [1:0]  datamode;  // transfer size
      logic        write;     // 1 = write, 0 = read
   } emesh_packet_t;

   // translated packet, 136 bits
   // dstaddr_hi is the upper word for 64-bit targets, zero in bypass
   typedef struct packed {
      logic [31:0]   dstaddr_hi;
      emesh_packet_t pkt;
   } emesh_xpacket_t;

   // ############################
   // translation table
   // ############################

   // one table write, one 32-bit half at a time
   typedef struct packed {
      logic                      en;
      logic [`EMMU_TABLE_AW-1:0] addr;   // entry index
      logic                      half;   // 0 = low word, 1 = high bits
      logic [31:0]               data;   // high half uses only 15:0
   } table_wr_t;

   // one table entry
   //   11:0  replaces dstaddr 31:20
   //   43:12 upper address word
   //   47:44 spare
   typedef logic [`EMMU_TABLE_DW-1:0] table_entry_t;

endpackage

// ==== source/emmu_regs.sv ====
`include "emmu_consts.svh"

module emmu_regs
#(
   parameter bit BID = 1'b0                   // block id, compared to addr bit 15
)
(
   input  logic                     rd_clk,
   input  logic                     rst_n,
   // config requests, no back-pressure
   input  logic                     reg_access,
   input  emesh_pkg::emesh_packet_t reg_packet,
   // table write port
   output emesh_pkg::table_wr_t     table_wr,
   // control register
   output logic                     mmu_en,
   // readback
   output logic                     reg_rvalid,
   output logic [31:0]              reg_rdata
);

   import emesh_pkg::*;

   logic                      bid_hit;        // request is for this block
   logic                      ctrl_sel;       // control space vs table space
   logic                      ctrl_wr;
   logic                      ctrl_rd;
   table_wr_t                 wr_next;        // decoded table write

   logic                      wr_en_q;
   logic [`EMMU_TABLE_AW-1:0] wr_addr_q;
   logic                      wr_half_q;
   logic [31:0]               wr_data_q;

   // ############################
   // decode
   // ############################

   assign bid_hit  = (reg_packet.dstaddr[`EMMU_BID_BIT] == BID);
   assign ctrl_sel = reg_packet.dstaddr[`EMMU_CTRL_SEL_BIT];

   assign ctrl_wr = reg_access & reg_packet.write & bid_hit & ctrl_sel;
   assign ctrl_rd = reg_access & ~reg_packet.write & bid_hit & ctrl_sel;

   // table space write
   always_comb
   begin
      wr_next.en   = reg_access & reg_packet.write & bid_hit & ~ctrl_sel;
      wr_next.addr = reg_packet.dstaddr[`EMMU_IDX_LSB +: `EMMU_TABLE_AW];  // 14:3
      wr_next.half = reg_packet.dstaddr[`EMMU_HALF_BIT];
      wr_next.data = reg_packet.data;
   end

   // ############################
   // table write register
   // ############################

   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
         wr_en_q <= 1'b0;
      else
         wr_en_q <= wr_next.en;     // one cycle strobe
   end

   // payload only loads on a real write
   always_ff @(posedge rd_clk)
   begin
      if (wr_next.en)
      begin
         wr_addr_q <= wr_next.addr;
         wr_half_q <= wr_next.half;
         wr_data_q <= wr_next.data;
      end
   end

   assign table_wr = '{en: wr_en_q, addr: wr_addr_q, half: wr_half_q, data: wr_data_q};

   // ############################
   // control reg and readback
   // ############################

   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mmu_en     <= 1'b0;        // bypass out of reset
         reg_rvalid <= 1'b0;
      end
      else
      begin
         if (ctrl_wr)
            mmu_en <= reg_packet.data[0];
         reg_rvalid <= ctrl_rd;     // exactly one cycle after request
      end
   end

   // enable in bit 0, rest zero
   always_ff @(posedge rd_clk)
   begin
      if (ctrl_rd)
         reg_rdata <= {31'd0, mmu_en};
   end

endmodule

// ==== source/emmu_table.sv ====
`include "emmu_consts.svh"

module emmu_table
(
   input  logic                      rd_clk,
   // config side
   input  emesh_pkg::table_wr_t      table_wr,
   // lookup side
   input  logic                      lookup_en,
   input  logic [`EMMU_TABLE_AW-1:0] lookup_idx,
   output logic [`EMMU_TABLE_DW-1:0] lookup_entry
);

   import emesh_pkg::*;

   localparam int DEPTH = 1 << `EMMU_TABLE_AW;

   table_entry_t mem [DEPTH];     // contents undefined until written
   logic         wr_hit;          // write and lookup to same entry

   // word-masked write, one half per request
   always_ff @(posedge rd_clk)
   begin
      if (table_wr.en)
      begin
         if (table_wr.half)
            mem[table_wr.addr][47:32] <= table_wr.data[15:0];
         else
            mem[table_wr.addr][31:0]  <= table_wr.data;
      end
   end

   assign wr_hit = table_wr.en & (table_wr.addr == lookup_idx);

   // registered read, write-first on a same-entry collision
   // so a lookup never sees a stale half
   always_ff @(posedge rd_clk)
   begin
      if (lookup_en)
      begin
         lookup_entry <= mem[lookup_idx];
         if (wr_hit & table_wr.half)
            lookup_entry[47:32] <= table_wr.data[15:0];
         else if (wr_hit)
            lookup_entry[31:0]  <= table_wr.data;
      end
   end

endmodule

// ==== source/emmu_xlate.sv ====
`include "emmu_consts.svh"

module emmu_xlate
(
   input  logic                      rd_clk,
   input  logic                      rst_n,
   // packet input, credit based
   input  logic                      in_valid,
   input  emesh_pkg::emesh_packet_t  in_packet,
   output logic                      in_credit,       // one pulse per fifo pop
   // control
   input  logic                      mmu_en,
   // table lookup
   output logic                      lookup_en,
   output logic [`EMMU_TABLE_AW-1:0] lookup_idx,
   input  logic [`EMMU_TABLE_DW-1:0] lookup_entry,
   // packet output, credit based
   output logic                      out_valid,
   output emesh_pkg::emesh_xpacket_t out_packet,
   input  logic                      out_credit       // one pulse per returned credit
);

   import emesh_pkg::*;

   localparam int DEPTH = `EMMU_FIFO_DEPTH;
   localparam int PW    = $clog2(DEPTH);                // fifo pointer width
   localparam int CW    = $clog2(`EMMU_OUT_CREDITS + 1);

   // lookup stage
   logic           s1_valid;
   logic           s1_en;           // mmu_en sampled with the packet
   emesh_packet_t  s1_pkt;
   emesh_xpacket_t s1_xpkt;         // translated, ready to push

   // output fifo
   emesh_xpacket_t fifo_mem [DEPTH];
   logic [PW-1:0]  wr_ptr;
   logic [PW-1:0]  rd_ptr;
   logic [PW:0]    fifo_cnt;        // 0..DEPTH
   logic           fifo_empty;
   logic           push;
   logic           pop;

   // downstream credits
   logic [CW-1:0]  out_cred;

   // ############################
   // lookup stage
   // ############################

   // table read issues in the in_valid cycle
   assign lookup_en  = in_valid;
   assign lookup_idx = in_packet.dstaddr[31:20];

   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
         s1_valid <= 1'b0;
      else
         s1_valid <= in_valid;
   end

   // packet lines up with the registered table output
   always_ff @(posedge rd_clk)
   begin
      if (in_valid)
      begin
         s1_pkt <= in_packet;
         s1_en  <= mmu_en;
      end
   end

   // ############################
   // address build
   // ############################

   always_comb
   begin
      s1_xpkt.pkt        = s1_pkt;          // srcaddr, data, modes untouched
      s1_xpkt.dstaddr_hi = 32'd0;           // bypass
      if (s1_en)
      begin
         s1_xpkt.pkt.dstaddr = {lookup_entry[11:0], s1_pkt.dstaddr[19:0]};
         s1_xpkt.dstaddr_hi  = lookup_entry[43:12];   // 64-bit upper word
      end
   end

   // ############################
   // output fifo
   // ############################

   // cannot overflow, sender never holds more credits than entries
   assign push       = s1_valid;
   assign fifo_empty = (fifo_cnt == '0);
   assign pop        = out_valid;

   always_ff @(posedge rd_clk)
   begin
      if (push)
         fifo_mem[wr_ptr] <= s1_xpkt;
   end

   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fifo_cnt <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;      // wraps, depth is a power of two
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
            2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
            default: fifo_cnt <= fifo_cnt;   // none or both
         endcase
      end
   end

   // ############################
   // credits
   // ############################

   assign out_valid  = ~fifo_empty & (out_cred != '0);
   assign out_packet = fifo_mem[rd_ptr];

   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out_cred  <= CW'(`EMMU_OUT_CREDITS);
         in_credit <= 1'b0;
      end
      else
      begin
         case ({out_credit, pop})
            2'b10:   out_cred <= out_cred + 1'b1;   // credit back
            2'b01:   out_cred <= out_cred - 1'b1;   // spent on send
            default: out_cred <= out_cred;
         endcase
         in_credit <= pop;      // freed fifo slot goes back upstream
      end
   end

endmodule

// ==== source/emmu_top.sv ====
`include "emmu_consts.svh"

module emmu_top
#(
   parameter bit BID = 1'b0                   // block id
)
(
   input  logic                      rd_clk,
   input  logic                      rst_n,
   // config
   input  logic                      reg_access,
   input  emesh_pkg::emesh_packet_t  reg_packet,
   output logic                      reg_rvalid,
   output logic [31:0]               reg_rdata,
   // packet in
   input  logic                      in_valid,
   input  emesh_pkg::emesh_packet_t  in_packet,
   output logic                      in_credit,
   // packet out
   output logic                      out_valid,
   output emesh_pkg::emesh_xpacket_t out_packet,
   input  logic                      out_credit
);

   import emesh_pkg::*;

   table_wr_t                 table_wr;      // regs -> table
   logic                      mmu_en;        // regs -> xlate
   logic                      lookup_en;
   logic [`EMMU_TABLE_AW-1:0] lookup_idx;
   logic [`EMMU_TABLE_DW-1:0] lookup_entry;  // table -> xlate, one cycle after lookup_en

   // config decode, enable reg
   emmu_regs #(.BID(BID)) u_regs (
      .rd_clk     (rd_clk),
      .rst_n      (rst_n),
      .reg_access (reg_access),
      .reg_packet (reg_packet),
      .table_wr   (table_wr),
      .mmu_en     (mmu_en),
      .reg_rvalid (reg_rvalid),
      .reg_rdata  (reg_rdata)
   );

   // 4096 x 48 lookup table
   emmu_table u_table (
      .rd_clk       (rd_clk),
      .table_wr     (table_wr),
      .lookup_en    (lookup_en),
      .lookup_idx   (lookup_idx),
      .lookup_entry (lookup_entry)
   );

   // lookup stage, output fifo, credits
   emmu_xlate u_xlate (
      .rd_clk       (rd_clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_packet    (in_packet),
      .in_credit    (in_credit),
      .mmu_en       (mmu_en),
      .lookup_en    (lookup_en),
      .lookup_idx   (lookup_idx),
      .lookup_entry (lookup_entry),
      .out_valid    (out_valid),
      .out_packet   (out_packet),
      .out_credit   (out_credit)
   );

endmodule

// ==== test/emmu_tb.sv ====
`include "emmu_consts.svh"

module emmu_tb;

   import emesh_pkg::*;

   localparam int CLK_HALF    = 5;                  // period 10
   localparam int CREDIT_WAIT = 200;                // longer than any hold
   localparam int DRAIN_WAIT  = 400;
   localparam int IN_CREDITS  = `EMMU_IN_CREDITS;
   localparam int OUT_CREDITS = `EMMU_OUT_CREDITS;

   logic           rd_clk;
   logic           rst_n;
   logic           reg_access;
   emesh_packet_t  reg_packet;
   logic           reg_rvalid;
   logic [31:0]    reg_rdata;
   logic           in_valid;
   emesh_packet_t  in_packet;
   logic           in_credit;
   logic           out_valid;
   emesh_xpacket_t out_packet;
   logic           out_credit;

   // expected packets from the stimulus side
   emesh_xpacket_t exp_q  [$];
   string          name_q [$];
   int             sent_q [$];      // cycle of the in_valid
   bit             lat_q  [$];      // 2-cycle latency applies

   int          cyc;                // rising edges so far
   int          spent;              // input credits used by the sender
   int          in_ret;             // in_credit pulses seen
   int          recv;               // packets taken at the output
   int          returned;           // out_credit pulses given
   int          owed_snap;          // receiver's credits at the last negedge
   bit          held_snap;
   int          lat_checks;
   int          hold_until;         // no credit return before this cycle
   int          hold_base_out;
   int          hold_base_in;
   logic [31:0] fld_seed;           // srcaddr and mode fields

   emmu_top #(.BID(1'b0)) UUT (
      .rd_clk     (rd_clk),
      .rst_n      (rst_n),
      .reg_access (reg_access),
      .reg_packet (reg_packet),
      .reg_rvalid (reg_rvalid),
      .reg_rdata  (reg_rdata),
      .in_valid   (in_valid),
      .in_packet  (in_packet),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_credit (out_credit)
   );

   // ############################
   // helpers
   // ############################

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic bit is_held();
      return cyc < hold_until;
   endfunction

   function automatic int owed();
      return recv - returned;       // credits the receiver still holds
   endfunction

   function automatic int in_avail();
      return IN_CREDITS - spent + in_ret;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic config_write(input string name, input logic [31:0] addr, data);
      reg_packet         = '0;
      reg_packet.dstaddr = addr;
      reg_packet.data    = data;
      reg_packet.write   = 1'b1;
      reg_access         = 1'b1;
      @(posedge rd_clk);
      #1;
      reg_access = 1'b0;
      assert (reg_rvalid === 1'b0)
      else report_failure($sformatf("config write %s raised reg_rvalid", name));
   endtask

   // readback is due exactly one cycle after the request
   task automatic config_read(input string name, input logic [31:0] addr, exp_data);
      reg_packet         = '0;
      reg_packet.dstaddr = addr;
      reg_packet.write   = 1'b0;
      reg_access         = 1'b1;
      @(posedge rd_clk);
      #1;
      reg_access = 1'b0;
      assert (reg_rvalid === 1'b1)
      else report_failure($sformatf("no reg_rvalid one cycle after config read %s", name));
      assert (reg_rdata === exp_data)
      else report_failure($sformatf("mismatch %s: expected %h actual %h",
                                    name, exp_data, reg_rdata));
   endtask

   task automatic send_packet(input string name,
                              input logic [31:0] dst, data, exp_dst, exp_hi);
      emesh_packet_t  pkt;
      emesh_xpacket_t exp_pkt;
      int             n;
      n = 0;
      while (in_avail() <= 0)
      begin
         @(posedge rd_clk);
         #1;
         n++;
         assert (n < CREDIT_WAIT)
         else report_failure($sformatf("no input credit came back for %s", name));
      end
      fld_seed     = lcg_next(fld_seed);
      pkt.srcaddr  = fld_seed;
      pkt.data     = data;
      pkt.dstaddr  = dst;
      pkt.ctrlmode = fld_seed[20:16];
      pkt.datamode = fld_seed[22:21];
      pkt.write    = fld_seed[23];
      exp_pkt             = '{dstaddr_hi: exp_hi, pkt: pkt};
      exp_pkt.pkt.dstaddr = exp_dst;
      // nothing in flight and a downstream credit on hand
      lat_q.push_back(recv == exp_q.size() && owed_snap < OUT_CREDITS);
      exp_q.push_back(exp_pkt);
      name_q.push_back(name);
      sent_q.push_back(cyc);
      in_valid  = 1'b1;
      in_packet = pkt;
      spent++;
      @(posedge rd_clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic drain(); // until all packets are out and all credits back
      int n;
      n = 0;
      while (recv != exp_q.size() || owed_snap != 0)
      begin
         @(posedge rd_clk);
         #1;
         n++;
         assert (n < DRAIN_WAIT)
         else report_failure("packets or output credits still outstanding after timeout");
      end
   endtask

   task automatic check_output();
      emesh_xpacket_t e;
      string          nm;
      assert (recv < exp_q.size())
      else report_failure("out_valid raised with no packet outstanding");
      e  = exp_q[recv];
      nm = name_q[recv];
      assert (out_packet.pkt.dstaddr === e.pkt.dstaddr)
      else report_failure($sformatf("mismatch %s dstaddr: expected %h actual %h",
                                    nm, e.pkt.dstaddr, out_packet.pkt.dstaddr));
      assert (out_packet.dstaddr_hi === e.dstaddr_hi)
      else report_failure($sformatf("mismatch %s dstaddr_hi: expected %h actual %h",
                                    nm, e.dstaddr_hi, out_packet.dstaddr_hi));
      assert (out_packet.pkt.data === e.pkt.data)
      else report_failure($sformatf("mismatch %s data: expected %h actual %h",
                                    nm, e.pkt.data, out_packet.pkt.data));
      assert (out_packet.pkt.srcaddr === e.pkt.srcaddr)
      else report_failure($sformatf("mismatch %s srcaddr: expected %h actual %h",
                                    nm, e.pkt.srcaddr, out_packet.pkt.srcaddr));
      assert (out_packet.pkt[7:0] === e.pkt[7:0])     // ctrlmode, datamode, write
      else report_failure($sformatf("mismatch %s mode bits: expected %h actual %h",
                                    nm, e.pkt[7:0], out_packet.pkt[7:0]));
      if (lat_q[recv])
      begin
         assert (cyc - sent_q[recv] == 2)
         else report_failure($sformatf("mismatch %s latency: expected 2 actual %0d",
                                       nm, cyc - sent_q[recv]));
         lat_checks++;
      end
   endtask

   // ############################
   // clock and cycle count
   // ############################

   initial
   begin
      rd_clk = 1'b0;
      forever #CLK_HALF rd_clk = ~rd_clk;
   end

   initial
   begin
      cyc = 0;
      forever
      begin
         @(posedge rd_clk);
         cyc++;
      end
   end

   // ############################
   // output monitor
   // ############################

   // sample mid-cycle when DUT outputs are settled
   initial
   begin
      recv       = 0;
      in_ret     = 0;
      lat_checks = 0;
      owed_snap  = 0;
      held_snap  = 1'b0;
      forever
      begin
         @(negedge rd_clk);
         if (rst_n === 1'b1)
         begin
            assert (!$isunknown(out_valid) && !$isunknown(in_credit))
            else report_failure("out_valid or in_credit is unknown after reset");
            if (in_credit)
               in_ret++;
            assert (in_avail() <= IN_CREDITS)
            else report_failure("more input credits returned than were spent");
            if (out_valid)
            begin
               check_output();
               recv++;
            end
            assert (owed() <= OUT_CREDITS)
            else report_failure("out_valid raised without an output credit");
            if (is_held())
            begin
               assert (recv - hold_base_out <= OUT_CREDITS)
               else report_failure("more packets than output credits during a hold");
               assert (in_ret - hold_base_in <= OUT_CREDITS)
               else report_failure("input credits kept returning with the fifo full");
            end
            owed_snap = owed();
            held_snap = is_held();
         end
      end
   end

   // ############################
   // output credit return
   // ############################

   initial
   begin
      logic [31:0] gap_seed;
      int          gap;
      gap_seed   = 32'd47026;
      gap        = 0;
      returned   = 0;
      out_credit = 1'b0;
      forever
      begin
         @(posedge rd_clk);
         #1;
         out_credit = 1'b0;
         if (!held_snap && owed() > 0)
         begin
            if (gap == 0)
            begin
               out_credit = 1'b1;
               returned++;
               gap_seed = lcg_next(gap_seed);
               gap      = 32'(gap_seed[17:16]);     // 0..3 idle cycles
            end
            else
               gap--;
         end
      end
   end

   // ############################
   // vector driven stimulus
   // ############################

   initial
   begin
      int               fd;
      int               code;
      int               n;
      bit               done;
      string            op;
      string            name;
      logic [31:0]      a0;
      logic [31:0]      a1;
      logic [31:0]      a2;
      logic [31:0]      a3;
      logic [8*256-1:0] skip;
      rst_n         = 1'b0;
      reg_access    = 1'b0;
      reg_packet    = '0;
      in_valid      = 1'b0;
      in_packet     = '0;
      spent         = 0;
      hold_until    = 0;
      hold_base_out = 0;
      hold_base_in  = 0;
      fld_seed      = 32'd47026;
      done          = 1'b0;
      fd = $fopen("test/emmu_vectors.txt", "r");
      assert (fd != 0)
      else report_failure("cannot open test/emmu_vectors.txt");
      repeat (16) @(posedge rd_clk);
      #1;
      rst_n = 1'b1;
      while (!done)
      begin
         code = $fscanf(fd, "%s", op);
         assert (code == 1)
         else report_failure("vector file ended before END");
         if (op.substr(0, 0) == "#")
            code = $fgets(skip, fd);              // comment line
         else if (op == "CW")
         begin
            code = $fscanf(fd, "%s %h %h", name, a0, a1);
            assert (code == 3) else report_failure("bad CW line in vector file");
            config_write(name, a0, a1);
         end
         else if (op == "CR")
         begin
            code = $fscanf(fd, "%s %h %h", name, a0, a1);
            assert (code == 3) else report_failure("bad CR line in vector file");
            config_read(name, a0, a1);
         end
         else if (op == "PK")
         begin
            code = $fscanf(fd, "%s %h %h %h %h", name, a0, a1, a2, a3);
            assert (code == 5) else report_failure("bad PK line in vector file");
            send_packet(name, a0, a1, a2, a3);
         end
         else if (op == "HOLD")
         begin
            code = $fscanf(fd, "%s %d", name, n);
            assert (code == 2) else report_failure("bad HOLD line in vector file");
            hold_base_out = recv;
            hold_base_in  = in_ret;
            hold_until    = cyc + n;
         end
         else if (op == "WAIT")
            drain();
         else if (op == "END")
            done = 1'b1;
         else
            report_failure($sformatf("unknown operation %s in vector file", op));
      end
      $fclose(fd);
      assert (recv == exp_q.size())
      else report_failure("packets still outstanding at END");
      assert (lat_checks > 0)
      else report_failure("no packet went through the minimum latency check");
      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+source
source/emesh_pkg.sv
source/emmu_regs.sv
source/emmu_table.sv
source/emmu_xlate.sv
source/emmu_top.sv
test/emmu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the emmu testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module emmu_tb -f src.f -o emmu_sim

# a fatal stop exits non-zero, tee keeps the pipeline going so the log decides
./obj_dir/emmu_sim 2>&1 | tee "$LOG"

if grep -qF ">>> FAIL" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -qF ">>> PASS" "$LOG"; then
   echo "simulation ended without a result line"
   exit 1
fi
echo "simulation passed"

// ==== test/emmu_vectors.txt ====
# CW name addr data | CR name addr exp_rdata | HOLD name cycles (decimal) | WAIT | END
# PK name dstaddr data exp_dstaddr exp_dstaddr_hi   (all values hex)
# bypass out of reset
CR rd_reset 00010000 00000000
PK bypass_a 12345678 deadbeef 12345678 00000000
PK bypass_b abc00010 00000001 abc00010 00000000
PK bypass_c fff0ffff 0badf00d fff0ffff 00000000
WAIT
# entry 0x123, both halves, then enable
CW tbl_123_hi 0000091c 00000000
CW tbl_123_lo 00000918 a5a5f789
CW ctrl_on 00010000 00000001
CR rd_on 00010000 00000001
PK xlate_a 12345678 11111111 78945678 000a5a5f
WAIT
# one half at a time, other half kept
CW tbl_123_hi2 0000091c 0000c3d2
PK upper_a 12300000 22222222 78900000 3d2a5a5f
CW tbl_123_lo2 00000918 00000abc
PK lower_keeps_hi 123fffff 33333333 abcfffff 3d200000
CW tbl_fff_lo 00007ff8 12345001
CW tbl_fff_hi 00007ffc 0000fedc
PK xlate_fff fff00abc 44444444 00100abc edc12345
WAIT
# wrong block id is ignored
CW ctrl_off_badbid 00018000 00000000
CR rd_still_on 00010000 00000001
CW tbl_123_lo_badbid 00008918 00000555
PK badbid_tbl 12311111 55555555 abc11111 3d200000
CW tbl_fff_hi_badbid 0000fffc 00000000
PK badbid_fff fffabcde 66666666 001abcde edc12345
WAIT
# disable and enable again
CW ctrl_off 00010000 00000000
CR rd_off 00010000 00000000
PK bypass_after 12345678 77777777 12345678 00000000
CW ctrl_on2 00010000 00000001
PK reenable 12300001 88888888 abc00001 3d200000
WAIT
# back-pressure, fifo fills while credits are held
HOLD hold_a 40
PK bp_0 12300000 a0000000 abc00000 3d200000
PK bp_1 fff00001 a0000001 00100001 edc12345
PK bp_2 12300002 a0000002 abc00002 3d200000
PK bp_3 fff00003 a0000003 00100003 edc12345
PK bp_4 12300004 a0000004 abc00004 3d200000
PK bp_5 fff00005 a0000005 00100005 edc12345
PK bp_6 12300006 a0000006 abc00006 3d200000
PK bp_7 fff00007 a0000007 00100007 edc12345
PK bp_8 12300008 a0000008 abc00008 3d200000
PK bp_9 fff00009 a0000009 00100009 edc12345
WAIT
# single packets, minimum latency
PK lat_a 12300abc b0000000 abc00abc 3d200000
WAIT
PK lat_b fff12345 b0000001 00112345 edc12345
WAIT
END
